//--- bench/branchUnitTb.sv
`default_nettype none
`timescale 1ns/100ps

`include "branch_macros.svh"

module branchUnitTb
	import branchPkg::*;
();

	// One row of the stimulus table
	typedef struct packed {
		cmpMode_t mode;
		branchOp_t op;
		Value a;
		Value b;
		Value pc;
		logic [21:0] disp;
		logic expTaken;
	} caseEntry_t;

	logic clk;
	logic arstN;
	branchReq_t req;
	branchResult_t res;
	caseEntry_t cases[$];
	logic [31:0] lfsrState;
	int errors;
	int checks;
	int latency;

	branchUnit branchUnit_i (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.res(res)
	);

	bind branchUnit branchUnitAssert branchUnitAssert_i (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.res(res)
	);

	// 4 ns period
	always #2 clk = !clk;

	// ==============================
	// Stimulus helpers
	// ==============================

	// Fibonacci LFSR with taps 32, 22, 2 and 1 that advances one step per bit
	function automatic logic nextBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic Value randomWord();
		Value w;
		w = '0;
		for (int i = 0; i < `VALUE_W; i++)
			w = {w[`VALUE_W-2:0], nextBit()};
		return w;
	endfunction

	// PC and displacement vary with the row number and odd rows jump backwards
	function automatic void addCase(cmpMode_t mode, branchOp_t op, Value a, Value b,
		logic expTaken);
		caseEntry_t e;
		int n;
		n = cases.size();
		e.mode = mode;
		e.op = op;
		e.a = a;
		e.b = b;
		e.pc = 64'hffff_8000_0000_0000 + Value'(n) * 64'h18;
		e.disp = (n % 2) ? 22'(-n * 5) : 22'(n * 3);
		e.expTaken = expTaken;
		cases.push_back(e);
	endfunction

	// All relational branches for one pair, from its eq, lt and unordered facts
	function automatic void addRelations(cmpMode_t mode, Value a, Value b, logic eq,
		logic lt, logic un);
		addCase(mode, JEQ, a, b, eq);
		addCase(mode, JNE, a, b, !eq);
		addCase(mode, JLT, a, b, lt);
		addCase(mode, JGE, a, b, !un && !lt);
		addCase(mode, JLE, a, b, lt || eq);
		addCase(mode, JGT, a, b, !un && !lt && !eq);
		// Ordered and unordered tests exist only for binary float
		addCase(mode, JOR, a, b, mode == CM_FLT && !un);
		addCase(mode, JUN, a, b, mode == CM_FLT && un);
	endfunction

	function automatic Value expectedTarget(Value pc, logic [21:0] disp);
		logic signed [`VALUE_W-1:0] offset;
		offset = $signed(disp);
		// Displacement counts instruction words of four bytes
		return pc + Value'(offset) * (64'd1 << `DISP_SHIFT);
	endfunction

	function automatic void buildCases();
		Value ra;
		Value rb;
		cmpMode_t cm;
		Value bits;
		int idx;
		// Zero tests work in every mode and relations only in the known ones
		for (int m = 0; m < 8; m++)
		begin
			cm = cmpMode_t'(m);
			addCase(cm, JEQZ, '0, '0, 1'b1);
			addCase(cm, JEQZ, 64'h5, '0, 1'b0);
			addCase(cm, JNEZ, 64'h5, '0, 1'b1);
			addCase(cm, DJMP, 64'h8000_0000_0000_0000, '0, 1'b1);
			addCase(cm, MJNEZ, '0, '0, 1'b0);
			addCase(cm, NOP, '0, '0, 1'b0);
			if (m == 2 || m > 4)
				addCase(cm, JEQ, 64'h3, 64'h3, 1'b0);
		end
		// Extreme displacements in both directions
		cases[cases.size()-1].disp = 22'h200000;
		cases[cases.size()-2].disp = 22'h1fffff;
		// Integer pairs follow, and in the last ones signed and unsigned orders disagree
		addRelations(CM_INT, 64'hffff_ffff_ffff_fffb, 64'h3, 1'b0, 1'b1, 1'b0);
		addRelations(CM_SGN, 64'h7, 64'hffff_ffff_ffff_fffe, 1'b0, 1'b0, 1'b0);
		addRelations(CM_INT, 64'd42, 64'd42, 1'b1, 1'b0, 1'b0);
		addRelations(CM_SGN, 64'h8000_0000_0000_0000, 64'h1, 1'b0, 1'b1, 1'b0);
		addRelations(CM_UNS, 64'hffff_ffff_ffff_ffff, 64'h1, 1'b0, 1'b0, 1'b0);
		addRelations(CM_UNS, 64'h1, 64'h8000_0000_0000_0000, 1'b0, 1'b1, 1'b0);
		// IEEE doubles 1.0, 2.0, -1.0, -2.0, the two zeros and a quiet NaN
		addRelations(CM_FLT, 64'h3ff0_0000_0000_0000, 64'h4000_0000_0000_0000, 0, 1, 0);
		addRelations(CM_FLT, 64'h4000_0000_0000_0000, 64'h3ff0_0000_0000_0000, 0, 0, 0);
		addRelations(CM_FLT, 64'h3ff0_0000_0000_0000, 64'h3ff0_0000_0000_0000, 1, 0, 0);
		addRelations(CM_FLT, 64'h0, 64'h8000_0000_0000_0000, 1, 0, 0);
		addRelations(CM_FLT, 64'hc000_0000_0000_0000, 64'hbff0_0000_0000_0000, 0, 1, 0);
		addRelations(CM_FLT, 64'hbff0_0000_0000_0000, 64'hc000_0000_0000_0000, 0, 0, 0);
		addRelations(CM_FLT, 64'hbff0_0000_0000_0000, 64'h3ff0_0000_0000_0000, 0, 1, 0);
		addRelations(CM_FLT, 64'h7ff8_0000_0000_0000, 64'h3ff0_0000_0000_0000, 0, 0, 1);
		addRelations(CM_FLT, 64'h3ff0_0000_0000_0000, 64'h7ff8_0000_0000_0000, 0, 0, 1);
		// Bits 0, 31 and 63 are set, and the junk in b above bit 5 is ignored
		bits = 64'h8000_0000_8000_0001;
		for (int k = 0; k < 3; k++)
		begin
			idx = (k == 0) ? 0 : (k == 1) ? 31 : 63;
			addCase(CM_INT, JBS, bits, Value'(idx) | 64'habc0, 1'b1);
			addCase(CM_INT, JBC, bits, Value'(idx) | 64'habc0, 1'b0);
			addCase(CM_UNS, JBC, ~bits, Value'(idx), 1'b1);
			addCase(CM_SGN, JBS, ~bits, Value'(idx), 1'b0);
			addCase(CM_FLT, JBS, bits, Value'(idx), 1'b0);
		end
		// Random pairs with every tenth one equal
		for (int i = 0; i < 60; i++)
		begin
			ra = randomWord();
			rb = (i % 10 == 0) ? ra : randomWord();
			cm = (i % 3 == 0) ? CM_INT : (i % 3 == 1) ? CM_SGN : CM_UNS;
			addRelations(cm, ra, rb, ra == rb,
				(cm == CM_UNS) ? (ra < rb) : ($signed(ra) < $signed(rb)), 1'b0);
		end
	endfunction

	// ==============================
	// Drive and check
	// ==============================

	task automatic driveCase(caseEntry_t e);
		req.valid = 1'b1;
		req.inst.jxx.opcode = e.op;
		req.inst.jxx.cm = e.mode;
		req.inst.jxx.disp = e.disp;
		req.pc = e.pc;
		req.a = e.a;
		req.b = e.b;
	endtask

	task automatic checkResult(int idx, caseEntry_t e);
		Value expTarget;
		logic ok;
		expTarget = expectedTarget(e.pc, e.disp);
		ok = 1'b1;
		checks++;
		if (res.valid !== 1'b1)
		begin
			$display("[ERROR] case %0d res.valid: got %h expected 1", idx, res.valid);
			ok = 1'b0;
		end
		if (res.taken !== e.expTaken)
		begin
			$display("[ERROR] case %0d res.taken: got %h expected %h", idx, res.taken,
				e.expTaken);
			ok = 1'b0;
		end
		if (res.target !== expTarget)
		begin
			$display("[ERROR] case %0d res.target: got %h expected %h", idx, res.target,
				expTarget);
			ok = 1'b0;
		end
		if (ok)
			$display("case %0d %s mode %0d ok", idx, e.op.name(), e.mode);
		else
			errors++;
	endtask

	// Used during reset and on cycles without a strobe
	task automatic checkIdle(string label);
		checks++;
		if (res.valid !== 1'b0 || res.taken !== 1'b0)
		begin
			$display("[ERROR] %s res.valid/res.taken: got %h/%h expected 0/0", label,
				res.valid, res.taken);
			errors++;
		end
		else
			$display("%s idle ok", label);
	endtask

	initial
	begin
		clk = 1'b0;
		arstN = 1'b1;
		req = '0;
		errors = 0;
		checks = 0;
		lfsrState = 32'hdffbf058;
		buildCases();
		@(negedge clk);
		arstN = 1'b0;
		// A taken strobe during reset must not reach the result register
		driveCase(cases[0]);
		repeat (2) @(posedge clk);
		@(negedge clk);
		checkIdle("reset");
		checks++;
		if (res.target !== '0)
		begin
			$display("[ERROR] reset res.target: got %h expected %h", res.target, 64'h0);
			errors++;
		end
		arstN = 1'b1;
		// The first request is still on req and also measures the latency after reset
		latency = 0;
		while (res.valid !== 1'b1 && latency < 8)
		begin
			@(negedge clk);
			latency++;
		end
		if (res.valid !== 1'b1)
		begin
			$display("Timeout: no valid result within 8 cycles after reset");
			errors++;
		end
		else if (latency != 1)
		begin
			$display("First result came %0d cycles after its request instead of one", latency);
			errors++;
		end
		checkResult(0, cases[0]);
		req.valid = 1'b0;
		@(negedge clk);
		checkIdle("gap");
		// Back-to-back strobes with each result checked one cycle later
		for (int i = 1; i < cases.size(); i++)
		begin
			driveCase(cases[i]);
			@(negedge clk);
			checkResult(i, cases[i]);
		end
		req.valid = 1'b0;
		@(negedge clk);
		checkIdle("tail");
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			branchUnit_i.branchUnitAssert_i.failCount);
		if (errors == 0 && branchUnit_i.branchUnitAssert_i.failCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/branchUnitTb_assert.sv
`default_nettype none
`timescale 1ns/100ps

module branchUnitAssert
	import branchPkg::*;
(
	input wire logic clk,
	input wire logic arstN,
	input branchReq_t req,
	input branchResult_t res
);

	// Read back by the testbench when it sums up the run
	int failCount = 0;

	// A branch can only be taken on a cycle that carries a result
	takenNeedsValid: assert property (@(posedge clk) disable iff (!arstN)
		res.taken |-> res.valid)
	else
	begin
		failCount++;
		$error("res.taken high while res.valid is low");
	end

	// Exactly one cycle of latency from strobe to result
	validOneCycleLater: assert property (@(posedge clk) disable iff (!arstN)
		req.valid |=> res.valid)
	else
	begin
		failCount++;
		$error("no result one cycle after a request");
	end

	// The result register stays cleared for the whole reset
	quietInReset: assert property (@(posedge clk) !arstN |-> !res.valid)
	else
	begin
		failCount++;
		$error("res.valid high during reset");
	end

endmodule

`default_nettype wire

//--- branchUnit.f
+incdir+hw
hw/branchPkg.sv
hw/fpCompare.sv
hw/branchEval.sv
hw/branchUnit.sv
bench/branchUnitTb_assert.sv
bench/branchUnitTb.sv

//--- hw/branchEval.sv
`default_nettype none
`timescale 1ns/100ps

`include "branch_macros.svh"

module branchEval
	import branchPkg::*;
(
	input Instruction inst,
	input Value a,
	input Value b,
	output logic taken
);

	// ==============================
	// Decode
	// ==============================

	branchOp_t op;
	cmpMode_t cm;

	// The opcode sits in the same place for every instruction
	assign op = inst.any.opcode;
	// Only branches carry a compare mode
	assign cm = inst.jxx.cm;

	// ==============================
	// Float compare
	// ==============================

	cmpFlags_t fltFlags;

	fpCompare fpCompare_i (
		.a(a),
		.b(b),
		.flags(fltFlags)
	);

	// ==============================
	// Integer compare
	// ==============================

	logic aZero;
	logic eqInt;
	logic ltSigned;
	logic ltUnsigned;
	logic ltInt;
	logic [`BITSEL_W-1:0] bitSel;
	logic aBit;

	assign aZero = a == {`VALUE_W{1'b0}};
	assign eqInt = a == b;
	assign ltSigned = $signed(a) < $signed(b);
	assign ltUnsigned = a < b;

	// CM_UNS is the only integer mode that orders without sign
	assign ltInt = (cm == CM_UNS) ? ltUnsigned : ltSigned;

	// Bit tests look at the bit of a picked by the low bits of b
	assign bitSel = b[`BITSEL_W-1:0];
	assign aBit = a[bitSel];

	logic intTaken;
	logic fltTaken;

	// Integer modes: relations, then bit tests
	always_comb
	begin
		case (op)
			JEQ: intTaken = eqInt;
			JNE: intTaken = !eqInt;
			JLT: intTaken = ltInt;
			JGE: intTaken = !ltInt;
			JLE: intTaken = ltInt | eqInt;
			JGT: intTaken = !(ltInt | eqInt);
			JBC: intTaken = !aBit;
			JBS: intTaken = aBit;
			default: intTaken = 1'b0;
		endcase
	end

	// Float mode reads one flag per opcode
	always_comb
	begin
		case (op)
			JEQ: fltTaken = fltFlags.eq;
			JNE: fltTaken = fltFlags.ne;
			JLT: fltTaken = fltFlags.lt;
			JGE: fltTaken = fltFlags.ge;
			JLE: fltTaken = fltFlags.le;
			JGT: fltTaken = fltFlags.gt;
			JOR: fltTaken = fltFlags.ord;
			JUN: fltTaken = fltFlags.un;
			default: fltTaken = 1'b0;
		endcase
	end

	// ==============================
	// Decision
	// ==============================

	// Zero tests work in every mode, so they are checked before the mode
	always_comb
	begin
		case (op)
			JEQZ: taken = aZero;
			JNEZ, DJMP, MJNEZ: taken = !aZero;
			default:
			begin
				case (cm)
					CM_INT, CM_SGN, CM_UNS: taken = intTaken;
					CM_FLT: taken = fltTaken;
					// Decimal float and unknown modes take no other branch
					default: taken = 1'b0;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/branchPkg.sv
`default_nettype none

`include "branch_macros.svh"

package branchPkg;

	// One operand, a program counter or a branch target
	typedef logic [`VALUE_W-1:0] Value;

	// Branch opcodes, with NOP covering every opcode that is not a branch
	typedef enum logic [6:0] {
		NOP   = 7'h00,
		JEQ   = 7'h20,
		JNE   = 7'h21,
		JLT   = 7'h22,
		JGE   = 7'h23,
		JLE   = 7'h24,
		JGT   = 7'h25,
		JBC   = 7'h26,
		JBS   = 7'h27,
		JOR   = 7'h28,
		JUN   = 7'h29,
		JEQZ  = 7'h2A,
		JNEZ  = 7'h2B,
		DJMP  = 7'h2C,
		MJNEZ = 7'h2D
	} branchOp_t;

	// Compare kinds; codes 5 to 7 are left unnamed and act as unknown modes
	typedef enum logic [2:0] {
		CM_INT = 3'd0,
		CM_FLT = 3'd1,
		CM_DFP = 3'd2,
		CM_SGN = 3'd3,
		CM_UNS = 3'd4
	} cmpMode_t;

	// ==============================
	// Instruction word, seen two ways
	// ==============================

	// The any view only knows where the opcode lives
	// The jxx view splits the rest into compare mode and word displacement
	typedef union packed {
		struct packed {
			branchOp_t opcode;
			logic [24:0] payload;
		} any;
		struct packed {
			branchOp_t opcode;
			cmpMode_t cm;
			logic signed [21:0] disp;
		} jxx;
	} Instruction;

	// Compare flag word, with zero in the reserved positions
	typedef struct packed {
		logic [5:0] rsvd15;
		logic ord;
		logic rsvd8;
		logic gt;
		logic ge;
		logic ne;
		logic un;
		logic rsvd3;
		logic le;
		logic lt;
		logic eq;
	} cmpFlags_t;

	// One branch entering the stage
	typedef struct packed {
		logic valid;
		Instruction inst;
		Value pc;
		Value a;
		Value b;
	} branchReq_t;

	// Registered outcome, one cycle after the request
	typedef struct packed {
		logic valid;
		logic taken;
		Value target;
	} branchResult_t;

endpackage

`default_nettype wire

//--- hw/branchUnit.sv
`default_nettype none
`timescale 1ns/100ps

`include "branch_macros.svh"

module branchUnit
	import branchPkg::*;
(
	input wire logic clk,
	input wire logic arstN,
	input branchReq_t req,
	output branchResult_t res
);

	// ==============================
	// Decision
	// ==============================

	logic takenNow;

	// The evaluator is purely combinational, so the decision is ready this cycle
	branchEval branchEval_i (
		.inst(req.inst),
		.a(req.a),
		.b(req.b),
		.taken(takenNow)
	);

	// ==============================
	// Target
	// ==============================

	// Displacement widened to a full word with its sign kept
	logic signed [`VALUE_W-1:0] dispExt;
	// Same displacement as a byte offset
	Value dispBytes;
	Value targetNow;

	assign dispExt = req.inst.jxx.disp;

	// The displacement counts instruction words
	assign dispBytes = Value'(dispExt <<< `DISP_SHIFT);

	// The target is formed for every request, taken or not
	assign targetNow = req.pc + dispBytes;

	// ==============================
	// Result register
	// ==============================

	// One cycle of latency and no back-pressure
	// Each edge overwrites the previous result
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			res.valid <= 1'b0;
			res.taken <= 1'b0;
			res.target <= '0;
		end
		else
		begin
			res.valid <= req.valid;
			// A cycle without a strobe never reports a taken branch
			res.taken <= req.valid & takenNow;
			res.target <= targetNow;
		end
	end

endmodule

`default_nettype wire

//--- hw/branch_macros.svh
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// Width of one operand and of the program counter
`define VALUE_W 64

// Number of low bits of b that index a bit of a for JBC and JBS
// Six bits reach every bit of a 64-bit operand
`define BITSEL_W 6

// The jxx displacement counts instruction words
// Shifting it left by two turns it into a byte offset
`define DISP_SHIFT 2

`endif

//--- hw/fpCompare.sv
`default_nettype none
`timescale 1ns/100ps

module fpCompare
	import branchPkg::*;
(
	input Value a,
	input Value b,
	output cmpFlags_t flags
);

	// IEEE double field widths
	localparam int EXP_W = 11;
	localparam int MAN_W = 52;

	// ==============================
	// Field split
	// ==============================

	logic signA;
	logic signB;
	logic [EXP_W-1:0] expA;
	logic [EXP_W-1:0] expB;
	logic [MAN_W-1:0] manA;
	logic [MAN_W-1:0] manB;

	// Magnitude is everything below the sign bit
	logic [EXP_W+MAN_W-1:0] magA;
	logic [EXP_W+MAN_W-1:0] magB;

	assign signA = a[EXP_W+MAN_W];
	assign signB = b[EXP_W+MAN_W];
	assign expA = a[EXP_W+MAN_W-1:MAN_W];
	assign expB = b[EXP_W+MAN_W-1:MAN_W];
	assign manA = a[MAN_W-1:0];
	assign manB = b[MAN_W-1:0];
	assign magA = {expA, manA};
	assign magB = {expB, manB};

	// ==============================
	// Basic relations
	// ==============================

	logic nanA;
	logic nanB;
	logic bothZero;
	logic un;
	logic eq;
	logic lt;

	// A NaN has an all-ones exponent and a nonzero fraction
	assign nanA = (&expA) && (manA != '0);
	assign nanB = (&expB) && (manB != '0);
	assign un = nanA | nanB;

	// Plus zero and minus zero differ only in the sign, yet compare equal
	assign bothZero = (magA == '0) && (magB == '0);

	assign eq = !un && ((a == b) || bothZero);

	always_comb
	begin
		lt = 1'b0;
		// Nothing is less than anything once a NaN is involved
		if (!un && !bothZero)
		begin
			case ({signA, signB})
				// Negative against positive is always below
				2'b10: lt = 1'b1;
				2'b01: lt = 1'b0;
				// Two positives order by magnitude
				2'b00: lt = magA < magB;
				// Two negatives order in reverse of their magnitude
				default: lt = magA > magB;
			endcase
		end
	end

	// The rest follows from eq, lt and un
	always_comb
	begin
		flags = '0;
		flags.eq = eq;
		flags.lt = lt;
		flags.le = lt | eq;
		flags.un = un;
		// Unordered operands count as not equal
		flags.ne = !eq;
		flags.ge = !un && !lt;
		flags.gt = !un && !(lt | eq);
		flags.ord = !un;
	end

endmodule

`default_nettype wire
